//--- mem_ring_stim.txt
# columns in hex: op addr wmask data gap
# op 1 is a write and 0 a read, gap 1 adds random idle cycles before the request
1 00000004 f 11223344 0
1 00000048 f a5a55a5a 0
1 00000090 f deadbeef 0
1 000000fc f 0badf00d 0
0 00000004 0 00000000 1
0 00000048 0 00000000 0
0 00000090 0 00000000 1
0 000000fc 0 00000000 0
# partial writes, each returns the word before it
1 00000004 1 000000aa 1
1 00000004 c 99880000 0
1 00000090 6 00cafe00 1
0 00000004 0 00000000 0
0 00000090 0 00000000 0
# addresses outside the memory
1 00000100 f ffffffff 1
1 00000104 f 12345678 0
0 80000004 0 00000000 0
0 00000004 0 00000000 0
# back to back burst
1 00000000 f cafef00d 0
1 00000040 f 01020304 0
1 00000080 f 55aa55aa 0
1 000000c0 f 87654321 0
0 00000000 0 00000000 0
0 00000040 0 00000000 0
0 00000080 0 00000000 0
0 000000c0 0 00000000 0
0 000000fc 0 00000000 0

//--- sources.f
ring_pkg.sv
req_injector.sv
mem_node.sv
rsp_collector.sv
mem_ring_top.sv
mem_ring_assertions.sv
tb_mem_ring.sv

//--- tb_mem_ring.sv
`timescale 1ns/10ps

module tb_mem_ring;

  import ring_pkg::*;

  localparam int MAX_REQ   = 64;
  localparam int MEM_BYTES = NODE_COUNT * SLICE_BYTES;

  logic   clk;
  logic   i_reset;
  logic   i_req_valid;
  logic   i_req_write;
  addr_t  i_req_addr;
  mask_t  i_req_wmask;
  data_t  i_req_wdata;
  logic   o_req_credit;
  logic   o_rsp_valid;
  data_t  o_rsp_data;
  logic   o_rsp_error;

  // requests as read from the stim file
  logic   req_write [MAX_REQ];
  addr_t  req_addr  [MAX_REQ];
  mask_t  req_wmask [MAX_REQ];
  data_t  req_wdata [MAX_REQ];
  bit     req_gap   [MAX_REQ];
  int     n_req;

  // byte model of the whole memory, undefined until written
  logic [7:0]  model_mem [MEM_BYTES];
  data_t       exp_data_q [$];
  bit          exp_err_q  [$];
  string       exp_name_q [$];

  credit_cnt_t credits;
  int          rsp_count;
  int          cycle_count;
  int          cycle_limit;
  string       rsp_name;
  data_t       rsp_exp_data;
  bit          rsp_exp_err;

  mem_ring_top u_dut (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_req_valid  (i_req_valid),
    .i_req_write  (i_req_write),
    .i_req_addr   (i_req_addr),
    .i_req_wmask  (i_req_wmask),
    .i_req_wdata  (i_req_wdata),
    .o_req_credit (o_req_credit),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_data   (o_rsp_data),
    .o_rsp_error  (o_rsp_error)
  );

  always #10 clk = ~clk;

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp)
    begin
      $display("Error: %s data expected 0x%08h actual 0x%08h", name, exp, act);
      $display("Done: errors found");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_error(input string name, input bit exp, input bit act);
    if (act !== exp)
    begin
      $display("Error: %s error flag expected %0b actual %0b", name, exp, act);
      $display("Done: errors found");
      $fatal(1, "error flag mismatch");
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] mask;
    logic [31:0] data;
    logic [31:0] gap;
    fd = $fopen("mem_ring_stim.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file mem_ring_stim.txt");
      $display("Done: errors found");
      $fatal(1, "missing stimulus file");
    end
    n_req = 0;
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      // skip comment lines and blank lines
      if (line.len() > 0 && line.getc(0) != 8'h23)
      begin
        n = $sscanf(line, "%h %h %h %h %h", op, addr, mask, data, gap);
        if (n == 5 && n_req < MAX_REQ)
        begin
          req_write[n_req] = op[0];
          req_addr[n_req]  = addr;
          req_wmask[n_req] = mask[3:0];
          req_wdata[n_req] = data;
          req_gap[n_req]   = gap[0];
          n_req++;
        end
      end
    end
    $fclose(fd);
    if (n_req == 0)
    begin
      $display("The stimulus file holds no requests");
      $display("Done: errors found");
      $fatal(1, "empty stimulus file");
    end
  endtask

  // expected response from the byte model, then apply a write
  task automatic model_request(input int idx);
    string name;
    data_t old_word;
    int    base;
    name = $sformatf("req %0d %s 0x%08h", idx, req_write[idx] ? "write" : "read",
                     req_addr[idx]);
    if (req_addr[idx] < MEM_BASE || req_addr[idx] >= MEM_BASE + MEM_BYTES)
    begin
      exp_data_q.push_back('0);
      exp_err_q.push_back(1'b1);
    end
    else
    begin
      base = int'(req_addr[idx] - MEM_BASE) & ~3;
      for (int k = 0; k < 4; k++)
      begin
        old_word[8*k +: 8] = model_mem[base + k];
        if (req_write[idx] && req_wmask[idx][k])
        begin
          model_mem[base + k] = req_wdata[idx][8*k +: 8];
        end
      end
      exp_data_q.push_back(old_word);
      exp_err_q.push_back(1'b0);
    end
    exp_name_q.push_back(name);
  endtask

  task automatic send_requests();
    int idx;
    int idle;
    idx     = 0;
    idle    = req_gap[0] ? ($urandom % 4) + 1 : 0;
    credits = credit_cnt_t'(CREDITS);
    while (idx < n_req)
    begin
      @(posedge clk);
      if (o_req_credit === 1'b1)
      begin
        if (credits == credit_cnt_t'(CREDITS))
        begin
          $display("A credit pulse came with no request outstanding");
          $display("Done: errors found");
          $fatal(1, "extra credit");
        end
        else
        begin
          credits = credits + 1'b1;
        end
      end
      if (idle > 0)
      begin
        idle--;
        i_req_valid <= 1'b0;
      end
      else if (credits > 0)
      begin
        i_req_valid <= 1'b1;
        i_req_write <= req_write[idx];
        i_req_addr  <= req_addr[idx];
        i_req_wmask <= req_wmask[idx];
        i_req_wdata <= req_wdata[idx];
        credits = credits - 1'b1;
        model_request(idx);
        idx++;
        if (idx < n_req && req_gap[idx])
        begin
          idle = ($urandom % 4) + 1;
        end
      end
      else
      begin
        // out of credits, wait for a pulse
        i_req_valid <= 1'b0;
      end
    end
    @(posedge clk);
    i_req_valid <= 1'b0;
  endtask

  // responses are checked in order as they come out
  always @(posedge clk)
  begin
    if (o_rsp_valid === 1'b1)
    begin
      if (exp_data_q.size() == 0)
      begin
        $display("A response came out with no request outstanding");
        $display("Done: errors found");
        $fatal(1, "unexpected response");
      end
      else
      begin
        rsp_name     = exp_name_q.pop_front();
        rsp_exp_data = exp_data_q.pop_front();
        rsp_exp_err  = exp_err_q.pop_front();
        check_error(rsp_name, rsp_exp_err, o_rsp_error);
        check_data(rsp_name, rsp_exp_data, o_rsp_data);
        rsp_count++;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit)
    begin
      $display("Timeout after %0d cycles with %0d of %0d responses received",
               cycle_count, rsp_count, n_req);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    clk         = 1'b0;
    i_reset     = 1'b1;
    i_req_valid = 1'b0;
    i_req_write = 1'b0;
    i_req_addr  = '0;
    i_req_wmask = '0;
    i_req_wdata = '0;
    rsp_count   = 0;
    cycle_count = 0;
    cycle_limit = 0;
    void'($urandom(32'ha1761ea1));
    for (int b = 0; b < MEM_BYTES; b++)
    begin
      model_mem[b] = 'x;
    end
    load_stim();
    cycle_limit = 20 * n_req + 100;

    repeat (5) @(posedge clk);
    i_reset <= 1'b0;

    send_requests();
    wait (rsp_count == n_req);
    // a few more cycles so a stray extra response gets caught
    repeat (NODE_COUNT + 4) @(posedge clk);

    if (rsp_count == n_req && exp_data_q.size() == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("Got %0d responses for %0d requests", rsp_count, n_req);
      $display("Done: errors found");
      $fatal(1, "response count mismatch");
    end
  end

endmodule

//--- mem_ring_assertions.sv
`timescale 1ns/10ps

module mem_ring_assertions (
  input logic                   clk,
  input logic                   i_reset,
  input logic                   i_push,
  input ring_pkg::credit_cnt_t  i_fifo_count,
  input logic                   i_credit,
  input logic                   i_rsp_valid,
  input logic                   i_rsp_error
);

  import ring_pkg::*;

  // requests pushed and not yet credited back
  int pending;

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      pending <= 0;
    end
    else
    begin
      pending <= pending + int'(i_push) - int'(i_credit);
    end
  end

  // host must hold a credit for each push
  a_no_push_when_full: assert property (@(posedge clk) disable iff (i_reset)
    i_push |-> (i_fifo_count != credit_cnt_t'(CREDITS)))
    else $error("push into a full injector FIFO");

  a_credit_needs_entry: assert property (@(posedge clk) disable iff (i_reset)
    i_credit |-> (pending != 0))
    else $error("credit pulse with the injector FIFO empty");

  // response outputs held low through reset
  a_rsp_low_in_reset: assert property (@(posedge clk)
    i_reset |=> (!i_rsp_valid && !i_rsp_error))
    else $error("response outputs active during reset");

endmodule

bind req_injector mem_ring_assertions u_injector_checks (
  .clk          (clk),
  .i_reset      (i_reset),
  .i_push       (i_req_valid),
  .i_fifo_count (count),
  .i_credit     (o_req_credit),
  .i_rsp_valid  (1'b0),
  .i_rsp_error  (1'b0)
);

bind rsp_collector mem_ring_assertions u_collector_checks (
  .clk          (clk),
  .i_reset      (i_reset),
  .i_push       (1'b0),
  .i_fifo_count ('0),
  .i_credit     (1'b0),
  .i_rsp_valid  (o_rsp_valid),
  .i_rsp_error  (o_rsp_error)
);

//--- mem_ring_top.sv
`timescale 1ns/10ps

module mem_ring_top (
  input  logic             clk,
  input  logic             i_reset,
  input  logic             i_req_valid,
  input  logic             i_req_write,
  input  ring_pkg::addr_t  i_req_addr,
  input  ring_pkg::mask_t  i_req_wmask,
  input  ring_pkg::data_t  i_req_wdata,
  output logic             o_req_credit,
  output logic             o_rsp_valid,
  output ring_pkg::data_t  o_rsp_data,
  output logic             o_rsp_error
);

  import ring_pkg::*;

  // link n feeds slice n, link NODE_COUNT feeds the collector
  logic   ring_req   [NODE_COUNT+1];
  logic   ring_ack   [NODE_COUNT+1];
  logic   ring_write [NODE_COUNT+1];
  addr_t  ring_addr  [NODE_COUNT+1];
  mask_t  ring_wmask [NODE_COUNT+1];
  data_t  ring_data  [NODE_COUNT+1];

  // nothing is acknowledged before the first slice
  assign ring_ack[0] = 1'b0;

  req_injector u_injector (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_req_valid  (i_req_valid),
    .i_req_write  (i_req_write),
    .i_req_addr   (i_req_addr),
    .i_req_wmask  (i_req_wmask),
    .i_req_wdata  (i_req_wdata),
    .o_req_credit (o_req_credit),
    .o_ring_req   (ring_req[0]),
    .o_ring_write (ring_write[0]),
    .o_ring_addr  (ring_addr[0]),
    .o_ring_wmask (ring_wmask[0]),
    .o_ring_data  (ring_data[0])
  );

  for (genvar n = 0; n < NODE_COUNT; n++)
  begin : g_node
    mem_node #(
      .NODE_INDEX (n)
    ) u_node (
      .clk     (clk),
      .i_reset (i_reset),
      .i_req   (ring_req[n]),
      .i_ack   (ring_ack[n]),
      .i_write (ring_write[n]),
      .i_addr  (ring_addr[n]),
      .i_wmask (ring_wmask[n]),
      .i_data  (ring_data[n]),
      .o_req   (ring_req[n+1]),
      .o_ack   (ring_ack[n+1]),
      .o_write (ring_write[n+1]),
      .o_addr  (ring_addr[n+1]),
      .o_wmask (ring_wmask[n+1]),
      .o_data  (ring_data[n+1])
    );
  end

  rsp_collector u_collector (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_ring_req  (ring_req[NODE_COUNT]),
    .i_ring_ack  (ring_ack[NODE_COUNT]),
    .i_ring_data (ring_data[NODE_COUNT]),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp_data  (o_rsp_data),
    .o_rsp_error (o_rsp_error)
  );

endmodule

//--- rsp_collector.sv
`timescale 1ns/10ps

module rsp_collector (
  input  logic             clk,
  input  logic             i_reset,
  input  logic             i_ring_req,
  input  logic             i_ring_ack,
  input  ring_pkg::data_t  i_ring_data,
  output logic             o_rsp_valid,
  output ring_pkg::data_t  o_rsp_data,
  output logic             o_rsp_error
);

  logic unclaimed;
  logic done;

  // req still high at the end of the ring means no slice owns the address
  assign unclaimed = i_ring_req & ~i_ring_ack;
  assign done      = i_ring_ack | unclaimed;

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      o_rsp_valid <= 1'b0;
      o_rsp_error <= 1'b0;
    end
    else
    begin
      o_rsp_valid <= done;
      o_rsp_error <= unclaimed;
    end
  end

  // unclaimed requests return zero
  always_ff @(posedge clk)
  begin
    if (unclaimed)
    begin
      o_rsp_data <= '0;
    end
    else
    begin
      o_rsp_data <= i_ring_data;
    end
  end

endmodule

//--- mem_node.sv
`timescale 1ns/10ps

module mem_node #(
  parameter int NODE_INDEX = 0
) (
  input  logic             clk,
  input  logic             i_reset,
  input  logic             i_req,
  input  logic             i_ack,
  input  logic             i_write,
  input  ring_pkg::addr_t  i_addr,
  input  ring_pkg::mask_t  i_wmask,
  input  ring_pkg::data_t  i_data,
  output logic             o_req,
  output logic             o_ack,
  output logic             o_write,
  output ring_pkg::addr_t  o_addr,
  output ring_pkg::mask_t  o_wmask,
  output ring_pkg::data_t  o_data
);

  import ring_pkg::*;

  // one byte array per lane
  logic [7:0]  lane_mem [$bits(mask_t)][SLICE_WORDS];

  addr_t       win_base;
  addr_t       win_offset;
  word_idx_t   word_idx;
  logic        hit;

  assign win_base = MEM_BASE + addr_t'(NODE_INDEX * SLICE_BYTES);

  // addresses below the base wrap to a large offset and miss
  assign win_offset = i_addr - win_base;
  assign word_idx   = win_offset[$bits(word_idx_t)+1:2];
  assign hit        = i_req & (win_offset < addr_t'(SLICE_BYTES));

  // a claimed request leaves with req low and ack high
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      o_req <= 1'b0;
      o_ack <= 1'b0;
    end
    else
    begin
      o_req <= i_req & ~hit;
      o_ack <= i_ack | hit;
    end
  end

  // link fields pass through every clock
  always_ff @(posedge clk)
  begin
    o_write <= i_write;
    o_addr  <= i_addr;
    o_wmask <= i_wmask;
    o_data  <= i_data;

    if (hit)
    begin
      for (int k = 0; k < $bits(mask_t); k++)
      begin
        // old contents go back, also on a write
        o_data[8*k +: 8] <= lane_mem[k][word_idx];

        if (i_write & i_wmask[k])
        begin
          lane_mem[k][word_idx] <= i_data[8*k +: 8];
        end
      end
    end
  end

endmodule

//--- req_injector.sv
`timescale 1ns/10ps

module req_injector (
  input  logic             clk,
  input  logic             i_reset,
  input  logic             i_req_valid,
  input  logic             i_req_write,
  input  ring_pkg::addr_t  i_req_addr,
  input  ring_pkg::mask_t  i_req_wmask,
  input  ring_pkg::data_t  i_req_wdata,
  output logic             o_req_credit,
  output logic             o_ring_req,
  output logic             o_ring_write,
  output ring_pkg::addr_t  o_ring_addr,
  output ring_pkg::mask_t  o_ring_wmask,
  output ring_pkg::data_t  o_ring_data
);

  import ring_pkg::*;

  logic                        fifo_write [CREDITS];
  addr_t                       fifo_addr  [CREDITS];
  mask_t                       fifo_wmask [CREDITS];
  data_t                       fifo_data  [CREDITS];
  logic [$clog2(CREDITS)-1:0]  wr_ptr;
  logic [$clog2(CREDITS)-1:0]  rd_ptr;
  credit_cnt_t                 count;
  logic                        pop;

  // the ring never stalls, so the head leaves whenever there is one
  assign pop          = (count != '0);
  assign o_req_credit = pop;

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (i_req_valid)
      begin
        wr_ptr <= (int'(wr_ptr) == CREDITS - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= (int'(rd_ptr) == CREDITS - 1) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + credit_cnt_t'(i_req_valid) - credit_cnt_t'(pop);
    end
  end

  // entry storage
  always_ff @(posedge clk)
  begin
    if (i_req_valid)
    begin
      fifo_write[wr_ptr] <= i_req_write;
      fifo_addr[wr_ptr]  <= i_req_addr;
      fifo_wmask[wr_ptr] <= i_req_wmask;
      fifo_data[wr_ptr]  <= i_req_wdata;
    end
  end

  // link 0
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      o_ring_req <= 1'b0;
    end
    else
    begin
      o_ring_req <= pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      o_ring_write <= fifo_write[rd_ptr];
      o_ring_addr  <= fifo_addr[rd_ptr];
      o_ring_wmask <= fifo_wmask[rd_ptr];
      o_ring_data  <= fifo_data[rd_ptr];
    end
  end

endmodule

//--- ring_pkg.sv
package ring_pkg;

  // byte address and data word on every ring link
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // bit k enables byte lane k
  typedef logic [3:0] mask_t;

  // ring shape
  localparam int NODE_COUNT  = 4;
  localparam int SLICE_WORDS = 16;

  // one window per slice, four bytes per word
  localparam int SLICE_BYTES = SLICE_WORDS * $bits(mask_t);

  // slice k starts at MEM_BASE + k * SLICE_BYTES
  localparam addr_t MEM_BASE = 32'h0000_0000;

  // word inside a slice, address bits 5:2
  typedef logic [$clog2(SLICE_WORDS)-1:0] word_idx_t;

  // injector fifo depth, also the host's starting credits
  localparam int CREDITS = 4;

  // wide enough to hold CREDITS itself
  typedef logic [$clog2(CREDITS+1)-1:0] credit_cnt_t;

endpackage
